/* design/pa_pkg.sv */
package pa_pkg;

	////////////////////////////////////////
	// widths and depths
	////////////////////////////////////////

	// register and operand width
	localparam int DataWidth = 16;
	localparam int RegCount = 32;
	localparam int RegAddrWidth = $clog2(RegCount);
	localparam int OpcodeWidth = 7;
	// one slot and one full bundle of two slots
	localparam int SlotWidth = 30;
	localparam int BundleWidth = 2 * SlotWidth;
	// cache holds one bundle per entry
	localparam int ICacheDepth = 256;
	localparam int ICacheAddrWidth = $clog2(ICacheDepth);
	localparam int PcWidth = 16;

	////////////////////////////////////////
	// opcodes
	////////////////////////////////////////

	localparam logic [OpcodeWidth-1:0] OpNop = 7'd0;
	localparam logic [OpcodeWidth-1:0] OpAdd = 7'd1;
	localparam logic [OpcodeWidth-1:0] OpSub = 7'd2;
	localparam logic [OpcodeWidth-1:0] OpAnd = 7'd3;
	localparam logic [OpcodeWidth-1:0] OpOr = 7'd4;
	localparam logic [OpcodeWidth-1:0] OpXor = 7'd5;
	localparam logic [OpcodeWidth-1:0] OpShl = 7'd6;
	// logical shift, zero fill from the top
	localparam logic [OpcodeWidth-1:0] OpShr = 7'd7;
	localparam logic [OpcodeWidth-1:0] OpMov = 7'd8;

	////////////////////////////////////////
	// stage records
	////////////////////////////////////////

	typedef logic [DataWidth-1:0] data_t;
	typedef logic [RegAddrWidth-1:0] regAddr_t;
	typedef logic [PcWidth-1:0] pc_t;

	// immFormat set means register-immediate
	typedef struct packed {
		logic valid;
		logic immFormat;
		logic [OpcodeWidth-1:0] opcode;
		regAddr_t primReg;
		data_t operand;
	} slot_t;

	// slot A occupies the upper half
	typedef struct packed {
		slot_t slotA;
		slot_t slotB;
	} bundle_t;

	typedef struct packed {
		logic enable;
		pc_t address;
		bundle_t bundle;
	} icacheWrite_t;

	typedef struct packed {
		logic valid;
		logic [OpcodeWidth-1:0] opcode;
		regAddr_t destReg;
		regAddr_t srcReg;
		data_t immediate;
		logic useImm;
		logic readsDest;
	} decoded_t;

	typedef struct packed {
		logic valid;
		logic [OpcodeWidth-1:0] opcode;
		regAddr_t destReg;
		data_t primary;
		data_t secondary;
	} operands_t;

	typedef struct packed {
		logic valid;
		regAddr_t addr;
		data_t data;
		logic overflow;
	} writeback_t;

endpackage

/* design/InstrCache.sv */
`timescale 1ns/10ps

module InstrCache (
	input logic clock_i,
	input logic reset_i,
	input pa_pkg::icacheWrite_t icacheWrite_i,
	output pa_pkg::pc_t pc_o,
	output pa_pkg::bundle_t bundle_o,
	output logic fetchValid_o
);

	// write strobe held for one cycle before it reaches the memory
	pa_pkg::icacheWrite_t writeReg;
	// one bundle per entry, contents survive reset
	pa_pkg::bundle_t mem [pa_pkg::ICacheDepth];

	////////////////////////////////////////
	// programming port
	////////////////////////////////////////

	// loads run while the core is held in reset
	always_ff @(posedge clock_i)
	begin
		writeReg <= icacheWrite_i;
		if (writeReg.enable)
		begin
			mem[writeReg.address[pa_pkg::ICacheAddrWidth-1:0]] <= writeReg.bundle;
		end
	end

	////////////////////////////////////////
	// pc and fetch
	////////////////////////////////////////

	always_ff @(posedge clock_i)
	begin
		// fetch register follows the pc every cycle
		bundle_o <= mem[pc_o[pa_pkg::ICacheAddrWidth-1:0]];
		if (reset_i)
		begin
			pc_o <= '0;
			fetchValid_o <= 1'b0;
		end
		else
		begin
			fetchValid_o <= 1'b1;
			// wrap back to the first bundle at the end of the cache
			if (pc_o == pa_pkg::pc_t'(pa_pkg::ICacheDepth - 1))
				pc_o <= '0;
			else
				pc_o <= pc_o + pa_pkg::pc_t'(1);
		end
	end

	// programming address must fall inside the cache
	assert property (@(posedge clock_i)
		icacheWrite_i.enable |-> (icacheWrite_i.address < pa_pkg::ICacheDepth));

endmodule

/* design/BundleParser.sv */
`timescale 1ns/10ps

module BundleParser (
	input logic clock_i,
	input logic reset_i,
	input pa_pkg::bundle_t bundle_i,
	input logic fetchValid_i,
	output pa_pkg::slot_t slotA_o,
	output pa_pkg::slot_t slotB_o
);

	// split point between the two slots
	pa_pkg::slot_t rawA;
	pa_pkg::slot_t rawB;

	// upper half is slot A, lower half slot B
	assign rawA = bundle_i[pa_pkg::BundleWidth-1:pa_pkg::SlotWidth];
	assign rawB = bundle_i[pa_pkg::SlotWidth-1:0];

	always_ff @(posedge clock_i)
	begin
		// slot fields move along unconditionally
		slotA_o <= rawA;
		slotB_o <= rawB;
		if (reset_i)
		begin
			slotA_o.valid <= 1'b0;
			slotB_o.valid <= 1'b0;
		end
		else
		begin
			// an invalid fetch kills both slots
			slotA_o.valid <= rawA.valid & fetchValid_i;
			slotB_o.valid <= rawB.valid & fetchValid_i;
		end
	end

endmodule

/* design/SlotDecoder.sv */
`timescale 1ns/10ps

module SlotDecoder (
	input logic clock_i,
	input logic reset_i,
	input pa_pkg::slot_t slot_i,
	output pa_pkg::decoded_t decoded_o
);

	// opcode is a real operation, nop and unknown codes drop out
	logic opKnown;
	pa_pkg::decoded_t decodeNext;

	assign opKnown = (slot_i.opcode != pa_pkg::OpNop) && (slot_i.opcode <= pa_pkg::OpMov);

	////////////////////////////////////////
	// classify the slot
	////////////////////////////////////////

	always_comb
	begin
		decodeNext.valid = slot_i.valid & opKnown;
		decodeNext.opcode = slot_i.opcode;
		// primary register is both the first source and the target
		decodeNext.destReg = slot_i.primReg;
		// second register sits in the low bits of the operand field
		decodeNext.srcReg = slot_i.operand[pa_pkg::RegAddrWidth-1:0];
		decodeNext.immediate = slot_i.operand;
		decodeNext.useImm = slot_i.immFormat;
		// mov overwrites the target without reading it
		decodeNext.readsDest = (slot_i.opcode != pa_pkg::OpMov);
	end

	always_ff @(posedge clock_i)
	begin
		decoded_o <= decodeNext;
		if (reset_i)
		begin
			decoded_o.valid <= 1'b0;
		end
	end

	// nothing outside add through mov travels on as valid
	assert property (@(posedge clock_i) disable iff (reset_i)
		decoded_o.valid |->
			(decoded_o.opcode inside {[pa_pkg::OpAdd:pa_pkg::OpMov]}));

endmodule

/* design/RegisterFile.sv */
`timescale 1ns/10ps

module RegisterFile (
	input logic clock_i,
	input logic reset_i,
	input pa_pkg::decoded_t decodedA_i,
	input pa_pkg::decoded_t decodedB_i,
	input pa_pkg::writeback_t writebackA_i,
	input pa_pkg::writeback_t writebackB_i,
	output pa_pkg::operands_t operandsA_o,
	output pa_pkg::operands_t operandsB_o
);

	pa_pkg::data_t regs [pa_pkg::RegCount];

	////////////////////////////////////////
	// read helpers
	////////////////////////////////////////

	// write-through read
	// a value landing this edge is seen by the bundle read on the same edge
	// slot B checked last so it overrides A on a shared target
	function automatic pa_pkg::data_t readReg(input pa_pkg::regAddr_t addr);
		pa_pkg::data_t value;
		value = regs[addr];
		if (writebackA_i.valid && (writebackA_i.addr == addr))
			value = writebackA_i.data;
		if (writebackB_i.valid && (writebackB_i.addr == addr))
			value = writebackB_i.data;
		return value;
	endfunction

	// operand pair for one slot
	function automatic pa_pkg::operands_t buildOperands(input pa_pkg::decoded_t dec);
		pa_pkg::operands_t ops;
		ops.valid = dec.valid;
		ops.opcode = dec.opcode;
		ops.destReg = dec.destReg;
		// mov has no first source, feed it zero
		ops.primary = dec.readsDest ? readReg(dec.destReg) : '0;
		ops.secondary = dec.useImm ? dec.immediate : readReg(dec.srcReg);
		return ops;
	endfunction

	////////////////////////////////////////
	// register array
	////////////////////////////////////////

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			for (int i = 0; i < pa_pkg::RegCount; i++)
				regs[i] <= '0;
		end
		else
		begin
			// B assigned after A so B wins a same-register collision
			if (writebackA_i.valid)
				regs[writebackA_i.addr] <= writebackA_i.data;
			if (writebackB_i.valid)
				regs[writebackB_i.addr] <= writebackB_i.data;
		end
	end

	// operand stage for both slots
	always_ff @(posedge clock_i)
	begin
		operandsA_o <= buildOperands(decodedA_i);
		operandsB_o <= buildOperands(decodedB_i);
		if (reset_i)
		begin
			operandsA_o.valid <= 1'b0;
			operandsB_o.valid <= 1'b0;
		end
	end

	// target address must be resolved whenever a result comes back
	assert property (@(posedge clock_i) disable iff (reset_i)
		writebackA_i.valid |-> !$isunknown(writebackA_i.addr));
	assert property (@(posedge clock_i) disable iff (reset_i)
		writebackB_i.valid |-> !$isunknown(writebackB_i.addr));

endmodule

/* design/ArithUnit.sv */
`timescale 1ns/10ps

module ArithUnit (
	input logic clock_i,
	input logic reset_i,
	input pa_pkg::operands_t operands_i,
	output pa_pkg::writeback_t writeback_o
);

	pa_pkg::data_t result;
	logic overflow;
	pa_pkg::data_t sum;
	pa_pkg::data_t diff;
	// shift amount only needs four bits for a 16-bit word
	logic [3:0] shiftAmt;

	assign sum = operands_i.primary + operands_i.secondary;
	assign diff = operands_i.primary - operands_i.secondary;
	assign shiftAmt = operands_i.secondary[3:0];

	////////////////////////////////////////
	// alu
	////////////////////////////////////////

	always_comb
	begin
		result = '0;
		overflow = 1'b0;
		case (operands_i.opcode)
			pa_pkg::OpAdd:
			begin
				result = sum;
				// same-sign inputs giving a sign flip
				overflow = (operands_i.primary[15] == operands_i.secondary[15]) &&
					(sum[15] != operands_i.primary[15]);
			end
			pa_pkg::OpSub:
			begin
				result = diff;
				// opposite-sign inputs where the result leaves the primary sign
				overflow = (operands_i.primary[15] != operands_i.secondary[15]) &&
					(diff[15] != operands_i.primary[15]);
			end
			pa_pkg::OpAnd: result = operands_i.primary & operands_i.secondary;
			pa_pkg::OpOr: result = operands_i.primary | operands_i.secondary;
			pa_pkg::OpXor: result = operands_i.primary ^ operands_i.secondary;
			pa_pkg::OpShl: result = operands_i.primary << shiftAmt;
			pa_pkg::OpShr: result = operands_i.primary >> shiftAmt;
			pa_pkg::OpMov: result = operands_i.secondary;
			default: result = '0;
		endcase
	end

	// result register doubles as the writeback port
	always_ff @(posedge clock_i)
	begin
		writeback_o.addr <= operands_i.destReg;
		writeback_o.data <= result;
		writeback_o.overflow <= overflow;
		if (reset_i)
			writeback_o.valid <= 1'b0;
		else
			writeback_o.valid <= operands_i.valid;
	end

	// a result on the port came from a known opcode the cycle before
	assert property (@(posedge clock_i) disable iff (reset_i)
		writeback_o.valid |-> ($past(operands_i.opcode) inside {[pa_pkg::OpAdd:pa_pkg::OpMov]}));

endmodule

/* design/PaCore.sv */
`timescale 1ns/10ps

module PaCore (
	input logic clock_i,
	input logic reset_i,
	input pa_pkg::icacheWrite_t icacheWrite_i,
	output pa_pkg::pc_t pc_o,
	output pa_pkg::writeback_t writebackA_o,
	output pa_pkg::writeback_t writebackB_o
);

	////////////////////////////////////////
	// stage links
	////////////////////////////////////////

	// fetch to parse
	pa_pkg::pc_t fetchPc;
	pa_pkg::bundle_t fetchBundle;
	logic fetchValid;
	// parse to decode
	pa_pkg::slot_t slotA;
	pa_pkg::slot_t slotB;
	// decode to register read
	pa_pkg::decoded_t decodedA;
	pa_pkg::decoded_t decodedB;
	// register read to alu
	pa_pkg::operands_t operandsA;
	pa_pkg::operands_t operandsB;

	InstrCache InstrCache_inst (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.icacheWrite_i(icacheWrite_i),
		.pc_o(fetchPc),
		.bundle_o(fetchBundle),
		.fetchValid_o(fetchValid)
	);

	BundleParser BundleParser_inst (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.bundle_i(fetchBundle),
		.fetchValid_i(fetchValid),
		.slotA_o(slotA),
		.slotB_o(slotB)
	);

	// one decoder per slot
	SlotDecoder SlotDecoderA_inst (.clock_i(clock_i), .reset_i(reset_i),
		.slot_i(slotA), .decoded_o(decodedA));
	SlotDecoder SlotDecoderB_inst (.clock_i(clock_i), .reset_i(reset_i),
		.slot_i(slotB), .decoded_o(decodedB));

	// results go straight back into the array
	RegisterFile RegisterFile_inst (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.decodedA_i(decodedA),
		.decodedB_i(decodedB),
		.writebackA_i(writebackA_o),
		.writebackB_i(writebackB_o),
		.operandsA_o(operandsA),
		.operandsB_o(operandsB)
	);

	ArithUnit ArithUnitA_inst (.clock_i(clock_i), .reset_i(reset_i),
		.operands_i(operandsA), .writeback_o(writebackA_o));
	ArithUnit ArithUnitB_inst (.clock_i(clock_i), .reset_i(reset_i),
		.operands_i(operandsB), .writeback_o(writebackB_o));

	// pc seen outside lags the fetch address by a cycle
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
			pc_o <= '0;
		else
			pc_o <= fetchPc;
	end

endmodule

/* verification/PaCoreTests.svh */
////////////////////////////////////////
// program building
////////////////////////////////////////

pa_pkg::slot_t noSlot = '0;

function automatic pa_pkg::slot_t makeSlot(input logic [pa_pkg::OpcodeWidth-1:0] opcode,
	input logic immFormat, input pa_pkg::regAddr_t primReg, input pa_pkg::data_t operand);
	return '{1'b1, immFormat, opcode, primReg, operand};
endfunction

task automatic addBundle(input pa_pkg::slot_t slotA, input pa_pkg::slot_t slotB);
	progQ.push_back(pa_pkg::bundle_t'{slotA, slotB});
endtask

// program the cache under reset, trailing empty bundles keep old code out of the pipe
task automatic loadProgram();
	int padded;
	pa_pkg::bundle_t word;
	padded = progQ.size() + 12;
	cycleLimit += 2 * padded + 40;
	@(posedge clock);
	reset <= 1'b1;
	for (int i = 0; i < padded; i++)
	begin
		word = '0;
		if (i < progQ.size())
			word = progQ[i];
		@(posedge clock);
		icacheWrite <= '{1'b1, pa_pkg::pc_t'(i), word};
	end
	@(posedge clock);
	icacheWrite <= '0;
	repeat (8) @(posedge clock);
	buildExpected();
	reset <= 1'b0;
endtask

// last bundle writes back when pc_o reaches its index plus four
task automatic waitResults();
	int lastPc;
	lastPc = progQ.size() + 8;
	while (expectA.size() != 0 || expectB.size() != 0 || pc < pa_pkg::pc_t'(lastPc))
		@(negedge clock);
endtask

task automatic runProgram();
	loadProgram();
	waitResults();
endtask

////////////////////////////////////////
// directed tests
////////////////////////////////////////

task automatic testPcCount();
	progQ.delete();
	loadProgram();
	for (int k = 0; k < 16; k++)
	begin
		@(posedge clock);
		@(negedge clock);
		checkPc(pc, pa_pkg::pc_t'(k));
	end
	waitResults();
endtask

task automatic testMoves();
	progQ.delete();
	for (int i = 0; i < 6; i++)
		addBundle(makeSlot(pa_pkg::OpMov, 1'b1, pa_pkg::regAddr_t'(i + 1), nextRandom()),
			makeSlot(pa_pkg::OpMov, 1'b1, pa_pkg::regAddr_t'(i + 17), nextRandom()));
	runProgram();
endtask

task automatic testArith();
	pa_pkg::regAddr_t dst;
	pa_pkg::regAddr_t src;
	progQ.delete();
	// r1 to r16 from the generator
	for (int i = 0; i < 8; i++)
		addBundle(makeSlot(pa_pkg::OpMov, 1'b1, pa_pkg::regAddr_t'(i + 1), nextRandom()),
			makeSlot(pa_pkg::OpMov, 1'b1, pa_pkg::regAddr_t'(i + 9), nextRandom()));
	addBundle(noSlot, noSlot);
	// slot A register-register on r1..r8, slot B immediate on r9..r16
	for (int op = 1; op <= 8; op++)
	begin
		dst = pa_pkg::regAddr_t'(nextRandom() % 8 + 1);
		src = pa_pkg::regAddr_t'(nextRandom() % 8 + 1);
		addBundle(makeSlot(7'(op), 1'b0, dst, pa_pkg::data_t'(src)),
			makeSlot(7'(op), 1'b1, pa_pkg::regAddr_t'(nextRandom() % 8 + 9), nextRandom()));
		addBundle(noSlot, noSlot);
	end
	runProgram();
endtask

task automatic testOrdering();
	progQ.delete();
	// neighbour slot and the next bundle read r1 before the write lands
	addBundle(makeSlot(pa_pkg::OpMov, 1'b1, 5'd1, 16'h1111),
		makeSlot(pa_pkg::OpMov, 1'b0, 5'd4, 16'd1));
	addBundle(makeSlot(pa_pkg::OpMov, 1'b0, 5'd2, 16'd1), noSlot);
	addBundle(makeSlot(pa_pkg::OpMov, 1'b0, 5'd3, 16'd1), noSlot);
	// both slots hit r5, B should stick
	addBundle(makeSlot(pa_pkg::OpMov, 1'b1, 5'd5, 16'hAAAA),
		makeSlot(pa_pkg::OpMov, 1'b1, 5'd5, 16'h5555));
	addBundle(noSlot, noSlot);
	addBundle(makeSlot(pa_pkg::OpMov, 1'b0, 5'd6, 16'd5),
		makeSlot(pa_pkg::OpAdd, 1'b0, 5'd7, 16'd5));
	runProgram();
endtask

task automatic testInvalid();
	pa_pkg::slot_t idle;
	progQ.delete();
	idle = makeSlot(pa_pkg::OpAdd, 1'b1, 5'd1, 16'd5);
	idle.valid = 1'b0;
	addBundle(idle, makeSlot(pa_pkg::OpNop, 1'b1, 5'd2, 16'd7));
	addBundle(makeSlot(7'd9, 1'b1, 5'd3, 16'd1), makeSlot(7'd127, 1'b0, 5'd4, 16'd1));
	// operands at the edges of the signed range
	addBundle(makeSlot(pa_pkg::OpMov, 1'b1, 5'd1, 16'h7FFF),
		makeSlot(pa_pkg::OpMov, 1'b1, 5'd2, 16'h8000));
	addBundle(noSlot, noSlot);
	addBundle(makeSlot(pa_pkg::OpAdd, 1'b1, 5'd1, 16'd1), makeSlot(pa_pkg::OpSub, 1'b1, 5'd2, 16'd1));
	addBundle(noSlot, noSlot);
	addBundle(makeSlot(pa_pkg::OpAdd, 1'b0, 5'd1, 16'd1), makeSlot(pa_pkg::OpSub, 1'b0, 5'd2, 16'd1));
	addBundle(makeSlot(pa_pkg::OpMov, 1'b1, 5'd9, 16'd1), noSlot);
	runProgram();
endtask

/* verification/PaCoreTb.sv */
`timescale 1ns/10ps

module PaCoreTb;

	logic clock;
	logic reset;
	pa_pkg::icacheWrite_t icacheWrite;
	pa_pkg::pc_t pc;
	pa_pkg::writeback_t writebackA;
	pa_pkg::writeback_t writebackB;

	// program of the running test and the model state built from it
	pa_pkg::bundle_t progQ[$];
	pa_pkg::data_t shadowRegs [pa_pkg::RegCount];
	// expected results per slot in program order
	pa_pkg::writeback_t expectA[$];
	pa_pkg::writeback_t expectB[$];
	int valueErrors = 0;
	int otherErrors = 0;
	int cycleCount = 0;
	// grows as each test loads its program
	int cycleLimit = 40;
	int unsigned randState = 68058;

	PaCore PaCore_inst (
		.clock_i(clock),
		.reset_i(reset),
		.icacheWrite_i(icacheWrite),
		.pc_o(pc),
		.writebackA_o(writebackA),
		.writebackB_o(writebackB)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#4 clock = ~clock;
	end

	// watchdog
	always @(posedge clock)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit)
		begin
			$display("timeout after %0d cycles, %0d results on slot A and %0d on slot B missing",
				cycleCount, expectA.size(), expectB.size());
			$display("*** FAILED ***");
			$finish;
		end
	end

	////////////////////////////////////////
	// random numbers and compares
	////////////////////////////////////////

	function automatic pa_pkg::data_t nextRandom();
		randState = randState * 32'd1103515245 + 32'd12345;
		// upper bits of the state are the better mixed ones
		return randState[30:15];
	endfunction

	task automatic checkPc(input pa_pkg::pc_t got, input pa_pkg::pc_t want);
		if (got !== want)
		begin
			valueErrors++;
			$display("** Error at %0d ns: pc_o is %0d, expected %0d", $time, got, want);
		end
	endtask

	task automatic checkWriteback(input pa_pkg::writeback_t got, input pa_pkg::writeback_t want,
		input bit slotB);
		if (got !== want)
		begin
			valueErrors++;
			$display("** Error at %0d ns: slot %s wrote r%0d=%h ovf %b, expected r%0d=%h ovf %b",
				$time, slotB ? "B" : "A", got.addr, got.data, got.overflow,
				want.addr, want.data, want.overflow);
		end
	endtask

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	// result of one slot against the shadow registers, valid low when nothing is written
	function automatic pa_pkg::writeback_t modelSlot(input pa_pkg::slot_t s);
		pa_pkg::writeback_t wb;
		pa_pkg::data_t a;
		pa_pkg::data_t b;
		int wide;
		wb = '0;
		if (!s.valid || s.opcode == pa_pkg::OpNop || s.opcode > pa_pkg::OpMov)
			return wb;
		// mov ignores its target, everything else reads it first
		a = (s.opcode == pa_pkg::OpMov) ? '0 : shadowRegs[s.primReg];
		b = s.immFormat ? s.operand : shadowRegs[s.operand[pa_pkg::RegAddrWidth-1:0]];
		wb.valid = 1'b1;
		wb.addr = s.primReg;
		case (s.opcode)
			pa_pkg::OpAdd: wide = int'($signed(a)) + int'($signed(b));
			pa_pkg::OpSub: wide = int'($signed(a)) - int'($signed(b));
			pa_pkg::OpAnd: wide = int'(a & b);
			pa_pkg::OpOr: wide = int'(a | b);
			pa_pkg::OpXor: wide = int'(a ^ b);
			pa_pkg::OpShl: wide = int'(a << b[3:0]);
			pa_pkg::OpShr: wide = int'(a >> b[3:0]);
			default: wide = int'(b);
		endcase
		wb.data = pa_pkg::data_t'(wide);
		// true sum outside the 16-bit signed range
		if (s.opcode == pa_pkg::OpAdd || s.opcode == pa_pkg::OpSub)
			wb.overflow = (wide > 32767) || (wide < -32768);
		return wb;
	endfunction

	function automatic void commitWrite(input pa_pkg::writeback_t wb);
		if (wb.valid)
			shadowRegs[wb.addr] = wb.data;
	endfunction

	task automatic buildExpected();
		pa_pkg::writeback_t prevA;
		pa_pkg::writeback_t prevB;
		pa_pkg::writeback_t curA;
		pa_pkg::writeback_t curB;
		prevA = '0;
		prevB = '0;
		foreach (shadowRegs[r])
			shadowRegs[r] = '0;
		expectA.delete();
		expectB.delete();
		foreach (progQ[n])
		begin
			// bundle n sees bundles up to n-2, its neighbour slot and bundle n-1 are hidden
			curA = modelSlot(progQ[n].slotA);
			curB = modelSlot(progQ[n].slotB);
			commitWrite(prevA);
			// B lands after A
			commitWrite(prevB);
			prevA = curA;
			prevB = curB;
			if (curA.valid)
				expectA.push_back(curA);
			if (curB.valid)
				expectB.push_back(curB);
		end
	endtask

	////////////////////////////////////////
	// writeback monitor
	////////////////////////////////////////

	task automatic takeWriteback(input bit slotB, input pa_pkg::writeback_t got);
		pa_pkg::writeback_t want;
		if (reset)
		begin
			otherErrors++;
			$display("slot %s wrote back while reset was held, at %0d ns", slotB ? "B" : "A", $time);
		end
		else if (!slotB && expectA.size() != 0)
		begin
			want = expectA.pop_front();
			checkWriteback(got, want, slotB);
		end
		else if (slotB && expectB.size() != 0)
		begin
			want = expectB.pop_front();
			checkWriteback(got, want, slotB);
		end
		else
		begin
			otherErrors++;
			$display("slot %s wrote r%0d although no result was due, at %0d ns",
				slotB ? "B" : "A", got.addr, $time);
		end
	endtask

	// outputs settle half a cycle after the edge
	always @(negedge clock)
	begin
		if (writebackA.valid === 1'b1)
			takeWriteback(1'b0, writebackA);
		if (writebackB.valid === 1'b1)
			takeWriteback(1'b1, writebackB);
	end

	`include "PaCoreTests.svh"

	initial
	begin
		reset = 1'b1;
		icacheWrite = '0;
		testPcCount();
		testMoves();
		testArith();
		testOrdering();
		testInvalid();
		$display("value errors: %0d, other errors: %0d", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* flist.f */
+incdir+verification
design/pa_pkg.sv
design/InstrCache.sv
design/BundleParser.sv
design/SlotDecoder.sv
design/RegisterFile.sv
design/ArithUnit.sv
design/PaCore.sv
verification/PaCoreTb.sv

/* Makefile */
TOP = PaCoreTb

.PHONY: all run lint clean

all: run

obj_dir/$(TOP): flist.f $(wildcard design/*.sv) $(wildcard verification/*)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f -o $(TOP)

run: obj_dir/$(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

lint:
	verilator --lint-only -Wall --top-module PaCore design/pa_pkg.sv design/InstrCache.sv \
		design/BundleParser.sv design/SlotDecoder.sv design/RegisterFile.sv \
		design/ArithUnit.sv design/PaCore.sv

clean:
	rm -rf obj_dir sim.log
